// ==== gb_pkg.sv ====
// shared types and address map for the console system bus
// bus requests are single cycle, no wait states
// unit_sel_e carries one extra source, svbk, for the bank register read

`default_nettype none

package gb_pkg;

	// ------------------------------------------------------------------
	// bus request, one per cycle
	// ------------------------------------------------------------------
	typedef struct packed {
		logic [15:0] addr;   // cpu address
		logic        rd;     // read strobe
		logic        wr;     // write strobe
		logic [7:0]  wdata;  // cpu write data
	} bus_req_t;

	// read source, registered in the decoder
	typedef enum logic [3:0] {
		SEL_NONE    = 4'd0,  // open bus
		SEL_JOYP    = 4'd1,
		SEL_SB      = 4'd2,  // dummy, reads open bus
		SEL_SC      = 4'd3,
		SEL_IF      = 4'd4,
		SEL_IE      = 4'd5,
		SEL_WRAM    = 4'd6,
		SEL_HRAM    = 4'd7,
		SEL_IRQ_VEC = 4'd8,  // acknowledge cycle
		SEL_SVBK    = 4'd9   // colour mode only
	} unit_sel_e;

	// interrupt bit index, lowest index wins
	typedef enum logic [2:0] {
		IRQ_VBLANK = 3'd0,
		IRQ_LCDC   = 3'd1,
		IRQ_TIMER  = 3'd2,
		IRQ_SERIAL = 3'd3,
		IRQ_JOYPAD = 3'd4
	} irq_src_e;

	localparam int IRQ_W = 5;

	// ------------------------------------------------------------------
	// io register addresses
	// ------------------------------------------------------------------
	localparam logic [15:0] ADDR_JOYP = 16'hFF00;  // P1
	localparam logic [15:0] ADDR_SB   = 16'hFF01;
	localparam logic [15:0] ADDR_SC   = 16'hFF02;
	localparam logic [15:0] ADDR_IF   = 16'hFF0F;
	localparam logic [15:0] ADDR_SVBK = 16'hFF70;  // wram bank
	localparam logic [15:0] ADDR_IE   = 16'hFFFF;

	// vector = base + 8 * source index
	localparam logic [7:0] IRQ_VEC_BASE = 8'h40;
	localparam logic [7:0] IRQ_VEC_NONE = 8'h55;  // nothing pending
	localparam logic [7:0] OPEN_BUS     = 8'hFF;

endpackage

`default_nettype wire

// ==== gb_bus_decode.sv ====
// address decode and read mux for the cpu strobe bus
// rd_data follows a read or acknowledge cycle by one clock and holds
// until the next one; writes never move the read select

`timescale 1ns/1ps
`default_nettype none

module gb_bus_decode (
	input  wire                   clk_cpu,
	input  wire                   reset,
	input  wire                   is_gbc,
	input  wire gb_pkg::bus_req_t bus,
	input  wire                   irq_ack,
	output logic                  joyp_wr,
	output logic                  sc_wr,
	output logic                  if_wr,
	output logic                  ie_wr,
	output logic                  svbk_wr,
	output logic                  wram_sel,
	output logic                  hram_sel,
	input  wire [7:0]             joyp_do,
	input  wire [7:0]             sc_do,
	input  wire [7:0]             if_do,
	input  wire [7:0]             ie_do,
	input  wire [7:0]             svbk_do,
	input  wire [7:0]             vec_do,
	input  wire [7:0]             wram_do,
	input  wire [7:0]             hram_do,
	output logic [7:0]            rd_data
);

	logic hit_joyp, hit_sb, hit_sc, hit_if, hit_ie, hit_svbk;
	gb_pkg::unit_sel_e sel_d;
	gb_pkg::unit_sel_e sel_q;

	// ------------------------------------------------------------------
	// address compare
	// ------------------------------------------------------------------
	assign hit_joyp = (bus.addr == gb_pkg::ADDR_JOYP);
	assign hit_sb   = (bus.addr == gb_pkg::ADDR_SB);
	assign hit_sc   = (bus.addr == gb_pkg::ADDR_SC);
	assign hit_if   = (bus.addr == gb_pkg::ADDR_IF);
	assign hit_ie   = (bus.addr == gb_pkg::ADDR_IE);
	assign hit_svbk = (bus.addr == gb_pkg::ADDR_SVBK);
	// c000-feff incl. echo area
	assign wram_sel = (bus.addr[15:14] == 2'b11) && (bus.addr[15:8] != 8'hFF);
	// ff80-fffe, ffff is IE
	assign hram_sel = (bus.addr[15:7] == 9'h1FF) && !hit_ie;

	assign joyp_wr = bus.wr && hit_joyp;
	assign sc_wr   = bus.wr && hit_sc;
	assign if_wr   = bus.wr && hit_if;
	assign ie_wr   = bus.wr && hit_ie;
	assign svbk_wr = bus.wr && hit_svbk && is_gbc;  // dmg has no bank reg

	// next read source
	always_comb begin
		if (irq_ack)                 sel_d = gb_pkg::SEL_IRQ_VEC;
		else if (hit_joyp)           sel_d = gb_pkg::SEL_JOYP;
		else if (hit_sb)             sel_d = gb_pkg::SEL_SB;
		else if (hit_sc)             sel_d = gb_pkg::SEL_SC;
		else if (hit_if)             sel_d = gb_pkg::SEL_IF;
		else if (hit_ie)             sel_d = gb_pkg::SEL_IE;
		else if (hit_svbk && is_gbc) sel_d = gb_pkg::SEL_SVBK;
		else if (wram_sel)           sel_d = gb_pkg::SEL_WRAM;
		else if (hram_sel)           sel_d = gb_pkg::SEL_HRAM;
		else                         sel_d = gb_pkg::SEL_NONE;
	end

	always_ff @(posedge clk_cpu) begin
		if (reset)
			sel_q <= gb_pkg::SEL_NONE;
		else if (bus.rd || irq_ack)  // only reads and acks retarget
			sel_q <= sel_d;
	end

	// ------------------------------------------------------------------
	// read mux, lines up with ram output register
	// ------------------------------------------------------------------
	always_comb begin
		case (sel_q)
			gb_pkg::SEL_JOYP:    rd_data = joyp_do;
			gb_pkg::SEL_SC:      rd_data = sc_do;
			gb_pkg::SEL_IF:      rd_data = if_do;
			gb_pkg::SEL_IE:      rd_data = ie_do;
			gb_pkg::SEL_SVBK:    rd_data = svbk_do;
			gb_pkg::SEL_WRAM:    rd_data = wram_do;
			gb_pkg::SEL_HRAM:    rd_data = hram_do;
			gb_pkg::SEL_IRQ_VEC: rd_data = vec_do;
			default:             rd_data = gb_pkg::OPEN_BUS;  // none, SB
		endcase
	end

	// one kind of cycle at a time, ack never shares a cycle with a request
	a_one_cycle_kind: assert property (@(posedge clk_cpu) disable iff (reset)
		!(bus.rd && bus.wr) && !((bus.rd || bus.wr) && irq_ack));

endmodule

`default_nettype wire

// ==== gb_irq_ctrl.sv ====
// IF / IE registers and vector generation
// the vector is captured on the ack cycle and its flag is cleared
// on the clock after irq_ack falls; cpu writes win over everything

`timescale 1ns/1ps
`default_nettype none

module gb_irq_ctrl (
	input  wire                      clk_cpu,
	input  wire                      reset,
	input  wire                      irq_ack,
	input  wire                      if_wr,
	input  wire                      ie_wr,
	input  wire [7:0]                wdata,
	input  wire [gb_pkg::IRQ_W-1:0]  irq_pulse,
	output logic [7:0]               if_do,
	output logic [7:0]               ie_do,
	output logic [7:0]               vec_do,
	output logic                     irq_n
);

	logic [gb_pkg::IRQ_W-1:0] if_r;
	logic [gb_pkg::IRQ_W-1:0] ie_r;
	logic [gb_pkg::IRQ_W-1:0] pending;
	logic                     pend_hit;
	gb_pkg::irq_src_e         pend_idx;
	logic                     ack_q;      // irq_ack one clock late
	logic                     ack_valid;  // a source was serviced
	gb_pkg::irq_src_e         ack_idx;
	logic [7:0]               vec_q;

	assign pending = if_r & ie_r;
	assign irq_n   = ~|pending;  // low as soon as flag and enable meet

	// lowest index has priority so scan from the top down
	always_comb begin
		pend_hit = 1'b0;
		pend_idx = gb_pkg::IRQ_VBLANK;
		for (int i = gb_pkg::IRQ_W - 1; i >= 0; i--) begin
			if (pending[i]) begin
				pend_hit = 1'b1;
				pend_idx = gb_pkg::irq_src_e'(i);
			end
		end
	end

	// ------------------------------------------------------------------
	// acknowledge capture
	// ------------------------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			ack_q     <= 1'b0;
			ack_valid <= 1'b0;
			ack_idx   <= gb_pkg::IRQ_VBLANK;
		end else begin
			ack_q <= irq_ack;
			if (irq_ack) begin
				ack_valid <= pend_hit;
				ack_idx   <= pend_idx;
			end
		end
	end

	// vector register held until the next ack
	always_ff @(posedge clk_cpu) begin
		if (irq_ack)
			vec_q <= pend_hit ? gb_pkg::IRQ_VEC_BASE + {2'b00, pend_idx, 3'b000}
			                  : gb_pkg::IRQ_VEC_NONE;
	end
	assign vec_do = vec_q;

	// ------------------------------------------------------------------
	// flag and enable registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r <= '0;
			ie_r <= '0;
		end else begin
			if_r <= if_r | irq_pulse;          // sources set
			if (ack_q && !irq_ack && ack_valid)
				if_r[ack_idx] <= 1'b0;         // falling ack clears serviced one
			if (if_wr)
				if_r <= wdata[gb_pkg::IRQ_W-1:0];
			if (ie_wr)
				ie_r <= wdata[gb_pkg::IRQ_W-1:0];
		end
	end

	assign if_do = {3'b111, if_r};
	assign ie_do = {3'b000, ie_r};

	// an ack taken while irq_n is low always returns a real vector
	a_ack_vec_real: assert property (@(posedge clk_cpu) disable iff (reset)
		(irq_ack && !irq_n) |=> (vec_do != gb_pkg::IRQ_VEC_NONE));

endmodule

`default_nettype wire

// ==== gb_serial_port.sv ====
// dummy serial port, nothing is shifted out or in
// only internal clock transfers complete; SB lives in the decoder as open bus
// a transfer lasts 8 periods of SERIAL_DIV clocks

`timescale 1ns/1ps
`default_nettype none

module gb_serial_port #(
	parameter int SERIAL_DIV = 512  // clocks per bit
) (
	input  wire        clk_cpu,
	input  wire        reset,
	input  wire        sc_wr,
	input  wire [7:0]  wdata,
	output logic [7:0] sc_do,
	output logic       irq
);

	localparam int DIV_W = (SERIAL_DIV > 2) ? $clog2(SERIAL_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LOAD = DIV_W'(SERIAL_DIV - 1);

	logic             sc_start;  // SC bit 7
	logic             sc_clk;    // SC bit 0, internal clock
	logic [DIV_W-1:0] div_cnt;
	logic [3:0]       bit_cnt;   // bits still to go
	logic             running;

	assign running = sc_start && sc_clk;
	// single pulse, start drops on the same edge
	assign irq     = running && (bit_cnt == 4'd0);

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sc_start <= 1'b0;
			sc_clk   <= 1'b0;
			div_cnt  <= DIV_LOAD;
			bit_cnt  <= 4'd8;
		end else if (sc_wr) begin
			sc_start <= wdata[7];
			sc_clk   <= wdata[0];
			if (wdata[7]) begin  // fresh transfer
				div_cnt <= DIV_LOAD;
				bit_cnt <= 4'd8;
			end
		end else if (running) begin
			if (bit_cnt == 4'd0) begin
				sc_start <= 1'b0;  // done
			end else if (div_cnt == '0) begin
				div_cnt <= DIV_LOAD;
				bit_cnt <= bit_cnt - 4'd1;
			end else begin
				div_cnt <= div_cnt - 1'b1;
			end
		end
	end

	assign sc_do = {sc_start, 6'h3F, sc_clk};

endmodule

`default_nettype wire

// ==== gb_joypad.sv ====
// P1 select latch and key matrix, keys are active high at the pins
// no debounce; an edge seen while switching groups also raises the irq

`timescale 1ns/1ps
`default_nettype none

module gb_joypad (
	input  wire        clk_cpu,
	input  wire        reset,
	input  wire        joyp_wr,
	input  wire [7:0]  wdata,
	input  wire [7:0]  joystick,
	input  wire [5:0]  joy_sgb,
	output logic [7:0] joyp_do,
	output logic [5:0] joy_p54,
	output logic       irq
);

	logic [1:0] p54;      // P15 P14, low selects
	logic [3:0] joy_p4;   // directions
	logic [3:0] joy_p5;   // buttons
	logic [7:0] line_d1;
	logic [7:0] line_d2;

	always_ff @(posedge clk_cpu) begin
		if (reset)
			p54 <= 2'b11;  // nothing selected
		else if (joyp_wr)
			p54 <= wdata[5:4];
	end

	// active low lines, forced high when group deselected
	assign joy_p4 = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{p54[0]}};
	assign joy_p5 = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p54[1]}};

	assign joy_p54 = {p54, joy_p4 & joy_p5};
	assign joyp_do = {2'b11, joy_sgb};  // key state comes back via joy_sgb

	// falling edge on any line, irq one clock after detect
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			line_d1 <= '1;
			line_d2 <= '1;
			irq     <= 1'b0;
		end else begin
			line_d1 <= {joy_p4, joy_p5};
			line_d2 <= line_d1;
			irq     <= |(line_d2 & ~line_d1);
		end
	end

endmodule

`default_nettype wire

// ==== gb_work_ram.sv ====
// work ram (c000-feff) and high ram (ff80-fffe), synchronous read
// WRAM_AW is 15 at most; bit 12 picks bank 0 or the SVBK bank
// in dmg mode the upper half is fixed to bank 1

`timescale 1ns/1ps
`default_nettype none

module gb_work_ram #(
	parameter int WRAM_AW = 15,
	parameter int HRAM_AW = 7
) (
	input  wire                   clk_cpu,
	input  wire                   reset,
	input  wire                   is_gbc,
	input  wire gb_pkg::bus_req_t bus,
	input  wire                   wram_sel,
	input  wire                   hram_sel,
	input  wire                   svbk_wr,
	output logic [7:0]            wram_do,
	output logic [7:0]            hram_do,
	output logic [7:0]            svbk_do
);

	logic [2:0]         bank;      // 1..7
	logic [2:0]         eff_bank;
	logic [14:0]        wram_idx;  // full 32k index
	logic [WRAM_AW-1:0] wram_addr;
	logic [HRAM_AW-1:0] hram_addr;
	logic [7:0]         wram_mem [2**WRAM_AW];
	logic [7:0]         hram_mem [2**HRAM_AW];
	logic [7:0]         wram_q;
	logic [7:0]         hram_q;

	// ------------------------------------------------------------------
	// SVBK bank register
	// ------------------------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset)
			bank <= 3'd1;
		else if (svbk_wr)
			bank <= (bus.wdata[2:0] == 3'd0) ? 3'd1 : bus.wdata[2:0];  // 0 -> 1
	end

	assign svbk_do  = {5'h1F, bank};
	assign eff_bank = is_gbc ? bank : 3'd1;

	assign wram_idx  = {bus.addr[12] ? eff_bank : 3'd0, bus.addr[11:0]};
	assign wram_addr = wram_idx[WRAM_AW-1:0];
	assign hram_addr = bus.addr[HRAM_AW-1:0];

	// ------------------------------------------------------------------
	// arrays where read data only moves on a read
	// ------------------------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (wram_sel && bus.wr)
			wram_mem[wram_addr] <= bus.wdata;
		if (wram_sel && bus.rd)
			wram_q <= wram_mem[wram_addr];
	end

	always_ff @(posedge clk_cpu) begin
		if (hram_sel && bus.wr)
			hram_mem[hram_addr] <= bus.wdata;
		if (hram_sel && bus.rd)
			hram_q <= hram_mem[hram_addr];
	end

	assign wram_do = wram_q;
	assign hram_do = hram_q;

	// a read right behind a write to the same high ram byte returns the new byte
	a_hram_raw: assert property (@(posedge clk_cpu) disable iff (reset)
		(hram_sel && bus.rd && $past(hram_sel && bus.wr) && (bus.addr == $past(bus.addr)))
		|=> (hram_do == $past(bus.wdata, 2)));

endmodule

`default_nettype wire

// ==== gb_sys_top.sv ====
// system bus glue around an external cpu
// vblank, lcdc and timer irqs arrive as one-clock pulses on irq_ext
// rd_data is valid one clock after a read or ack cycle

`timescale 1ns/1ps
`default_nettype none

module gb_sys_top #(
	parameter int SERIAL_DIV = 512,
	parameter int WRAM_AW    = 15,
	parameter int HRAM_AW    = 7
) (
	input  wire                   clk_cpu,
	input  wire                   reset,
	input  wire                   is_gbc,     // colour mode
	input  wire gb_pkg::bus_req_t bus,
	input  wire                   irq_ack,
	input  wire [2:0]             irq_ext,    // timer, lcdc, vblank
	input  wire [7:0]             joystick,
	input  wire [5:0]             joy_sgb,
	output logic [7:0]            rd_data,
	output logic                  irq_n,
	output logic [5:0]            joy_p54
);

	logic joyp_wr, sc_wr, if_wr, ie_wr, svbk_wr;
	logic wram_sel, hram_sel;
	logic [7:0] joyp_do, sc_do, if_do, ie_do, svbk_do, vec_do, wram_do, hram_do;
	logic serial_irq;
	logic joy_irq;
	logic [gb_pkg::IRQ_W-1:0] irq_pulse;

	// ------------------------------------------------------------------
	// decode and read mux
	// ------------------------------------------------------------------
	gb_bus_decode u_decode (
		.clk_cpu (clk_cpu),  .reset   (reset),    .is_gbc  (is_gbc),
		.bus     (bus),      .irq_ack (irq_ack),
		.joyp_wr (joyp_wr),  .sc_wr   (sc_wr),    .if_wr   (if_wr),
		.ie_wr   (ie_wr),    .svbk_wr (svbk_wr),
		.wram_sel(wram_sel), .hram_sel(hram_sel),
		.joyp_do (joyp_do),  .sc_do   (sc_do),    .if_do   (if_do),
		.ie_do   (ie_do),    .svbk_do (svbk_do),  .vec_do  (vec_do),
		.wram_do (wram_do),  .hram_do (hram_do),  .rd_data (rd_data)
	);

	// irq bits in priority order
	assign irq_pulse[gb_pkg::IRQ_VBLANK] = irq_ext[0];
	assign irq_pulse[gb_pkg::IRQ_LCDC]   = irq_ext[1];
	assign irq_pulse[gb_pkg::IRQ_TIMER]  = irq_ext[2];
	assign irq_pulse[gb_pkg::IRQ_SERIAL] = serial_irq;
	assign irq_pulse[gb_pkg::IRQ_JOYPAD] = joy_irq;

	gb_irq_ctrl u_irq (
		.clk_cpu (clk_cpu), .reset (reset), .irq_ack (irq_ack),
		.if_wr   (if_wr),   .ie_wr (ie_wr), .wdata   (bus.wdata),
		.irq_pulse (irq_pulse),
		.if_do   (if_do),   .ie_do (ie_do), .vec_do  (vec_do),
		.irq_n   (irq_n)
	);

	// ------------------------------------------------------------------
	// io units
	// ------------------------------------------------------------------
	gb_serial_port #(.SERIAL_DIV(SERIAL_DIV)) u_serial (
		.clk_cpu (clk_cpu), .reset (reset), .sc_wr (sc_wr),
		.wdata   (bus.wdata), .sc_do (sc_do), .irq (serial_irq)
	);

	gb_joypad u_joypad (
		.clk_cpu  (clk_cpu),  .reset   (reset),   .joyp_wr (joyp_wr),
		.wdata    (bus.wdata), .joystick (joystick), .joy_sgb (joy_sgb),
		.joyp_do  (joyp_do),  .joy_p54 (joy_p54), .irq     (joy_irq)
	);

	gb_work_ram #(.WRAM_AW(WRAM_AW), .HRAM_AW(HRAM_AW)) u_ram (
		.clk_cpu  (clk_cpu),  .reset    (reset),    .is_gbc  (is_gbc),
		.bus      (bus),      .wram_sel (wram_sel), .hram_sel(hram_sel),
		.svbk_wr  (svbk_wr),  .wram_do  (wram_do),  .hram_do (hram_do),
		.svbk_do  (svbk_do)
	);

endmodule

`default_nettype wire

// ==== tb_gb_sys.sv ====
// directed testbench for the console bus glue with SERIAL_DIV cut to 16
// stimulus changes on the rising edge and results are sampled on the falling edge
// wait loops are bounded by a poll count

`timescale 1ns/1ps
`default_nettype none

module tb_gb_sys;

	localparam int CLK_HALF = 20;  // 40 ns period

	logic             clk_cpu;
	logic             reset;
	logic             is_gbc;
	gb_pkg::bus_req_t bus;
	logic             irq_ack;
	logic [2:0]       irq_ext;   // timer lcdc vblank
	logic [7:0]       joystick;
	logic [5:0]       joy_sgb;
	wire  [7:0]       rd_data;
	wire              irq_n;
	wire  [5:0]       joy_p54;

	logic [31:0] rng_state;
	int          errors;
	int          tests_run;
	int          tests_failed;

	gb_sys_top #(.SERIAL_DIV(16)) u_dut (
		.clk_cpu (clk_cpu), .reset   (reset),   .is_gbc  (is_gbc),
		.bus     (bus),     .irq_ack (irq_ack), .irq_ext (irq_ext),
		.joystick(joystick), .joy_sgb (joy_sgb),
		.rd_data (rd_data), .irq_n   (irq_n),   .joy_p54 (joy_p54)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #CLK_HALF clk_cpu = ~clk_cpu;
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %02h expected %02h", $time, what, got, exp);
			errors++;
		end
	endtask

	// one write cycle that lands on the edge ending it
	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_cpu);
		bus <= {addr, 1'b0, 1'b1, data};
		@(posedge clk_cpu);
		bus <= '0;
	endtask

	// one read cycle with data valid after the next edge
	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
		@(posedge clk_cpu);
		bus <= {addr, 1'b1, 1'b0, 8'h00};
		@(posedge clk_cpu);
		bus <= '0;
		@(negedge clk_cpu);
		data = rd_data;
	endtask

	task automatic read_check(input logic [15:0] addr, input logic [7:0] exp, input string what);
		logic [7:0] got;
		bus_read(addr, got);
		check_byte(what, got, exp);
	endtask

	// acknowledge cycle returning the vector
	task automatic ack_cycle(output logic [7:0] vec);
		@(posedge clk_cpu);
		irq_ack <= 1'b1;
		@(posedge clk_cpu);
		irq_ack <= 1'b0;
		@(negedge clk_cpu);
		vec = rd_data;
	endtask

	task automatic wait_irq_n(input logic level, input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk_cpu);
		while (irq_n !== level && n < limit) begin
			@(negedge clk_cpu);
			n++;
		end
		if (irq_n !== level) begin
			$display("TIMEOUT at %0t: irq_n never went to %0b (%s)", $time, level, what);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed, %0d errors", name, errors - err_start);
			tests_failed++;
		end
	endtask

	// ----------------------------------------------------------------------
	// tests
	// ----------------------------------------------------------------------
	task automatic test_reset_open_bus();
		int e0;
		e0 = errors;
		if (irq_n !== 1'b1) begin
			$display("CHECK FAILED at %0t: irq_n low after reset", $time);
			errors++;
		end
		if (joy_p54 !== 6'b11_1111) begin
			$display("CHECK FAILED at %0t: joy_p54 after reset, got %b", $time, joy_p54);
			errors++;
		end
		read_check(16'hFF0F, 8'hE0, "IF after reset");
		read_check(16'hFFFF, 8'h00, "IE after reset");
		read_check(16'hFF02, 8'h7E, "SC after reset");
		read_check(16'hFF70, 8'hF9, "SVBK after reset");  // bank 1
		read_check(16'h1234, 8'hFF, "unmapped 1234");
		read_check(16'hFF40, 8'hFF, "dropped FF40");
		finish_test("reset_open_bus", e0);
	endtask

	task automatic test_ram_banking();
		int e0;
		logic [7:0]  hram_exp [127];
		logic [11:0] off [8];
		logic [7:0]  bank0_exp [8];
		logic [7:0]  bank_exp [8][8];
		logic [31:0] r;
		e0 = errors;
		for (int i = 0; i < 127; i++) begin
			r = lcg_next();
			hram_exp[i] = r[15:8];
			bus_write(16'hFF80 + 16'(i), hram_exp[i]);
		end
		for (int k = 0; k < 8; k++) begin
			r = lcg_next();
			off[k] = {k[2:0], r[8:0]};  // distinct offsets
			bank0_exp[k] = r[23:16];
			bus_write({4'hC, off[k]}, bank0_exp[k]);
		end
		for (int b = 1; b < 8; b++) begin
			bus_write(16'hFF70, 8'(b));
			for (int k = 0; k < 8; k++) begin
				r = lcg_next();
				bank_exp[b][k] = {b[2:0], r[12:8]};  // bank in top bits keeps banks apart
				bus_write({4'hD, off[k]}, bank_exp[b][k]);
			end
		end
		// read back everything
		for (int i = 0; i < 127; i++)
			read_check(16'hFF80 + 16'(i), hram_exp[i], "hram readback");
		for (int k = 0; k < 8; k++)
			read_check({4'hC, off[k]}, bank0_exp[k], "wram bank 0 readback");
		for (int b = 1; b < 8; b++) begin
			bus_write(16'hFF70, 8'(b));
			read_check(16'hFF70, 8'hF8 | 8'(b), "SVBK readback");
			for (int k = 0; k < 8; k++)
				read_check({4'hD, off[k]}, bank_exp[b][k], "wram banked readback");
		end
		bus_write(16'hFF70, 8'h00);
		read_check(16'hFF70, 8'hF9, "SVBK write of 0");
		// mono mode has no bank register
		@(posedge clk_cpu);
		is_gbc <= 1'b0;
		bus_write(16'hFF70, 8'h03);
		read_check(16'hFF70, 8'hFF, "SVBK in mono mode");
		@(posedge clk_cpu);
		is_gbc <= 1'b1;
		read_check(16'hFF70, 8'hF9, "SVBK kept after mono write");
		finish_test("ram_banking", e0);
	endtask

	task automatic test_irq_priority();
		int e0;
		logic [7:0] vec;
		e0 = errors;
		bus_write(16'hFF0F, 8'h00);
		bus_write(16'hFFFF, 8'h1F);
		@(posedge clk_cpu);
		irq_ext <= 3'b110;  // lcdc and timer
		@(posedge clk_cpu);
		irq_ext <= 3'b000;
		wait_irq_n(1'b0, 4, "after lcdc and timer pulses");
		ack_cycle(vec);
		check_byte("vector for lcdc", vec, 8'h48);
		read_check(16'hFF0F, 8'hE4, "IF after lcdc ack");
		ack_cycle(vec);
		check_byte("vector for timer", vec, 8'h50);
		wait_irq_n(1'b1, 4, "after timer ack");
		ack_cycle(vec);
		check_byte("vector with nothing pending", vec, 8'h55);
		finish_test("irq_priority", e0);
	endtask

	task automatic test_serial();
		int e0;
		int polls;
		logic [7:0] sc;
		e0 = errors;
		bus_write(16'hFF0F, 8'h00);
		bus_write(16'hFFFF, 8'h08);
		bus_write(16'hFF02, 8'h81);  // start with internal clock
		polls = 0;
		sc = 8'hFF;
		while (sc[7] && polls < 200) begin
			bus_read(16'hFF02, sc);
			polls++;
		end
		if (sc[7]) begin
			$display("TIMEOUT at %0t: serial transfer never finished", $time);
			errors++;
		end
		check_byte("SC after transfer", sc, 8'h7F);
		read_check(16'hFF0F, 8'hE8, "IF after transfer");
		if (irq_n !== 1'b0) begin
			$display("CHECK FAILED at %0t: irq_n high after serial irq", $time);
			errors++;
		end
		finish_test("serial", e0);
	endtask

	task automatic test_joypad();
		int e0;
		int polls;
		int zeros;
		logic [7:0]  ifv;
		logic [31:0] r;
		e0 = errors;
		bus_write(16'hFFFF, 8'h10);
		bus_write(16'hFF0F, 8'h00);
		bus_write(16'hFF00, 8'h20);  // select directions
		@(negedge clk_cpu);
		if (joy_p54 !== 6'b10_1111) begin
			$display("CHECK FAILED at %0t: joy_p54 idle, got %b", $time, joy_p54);
			errors++;
		end
		// all directions pressed pull every line low
		@(posedge clk_cpu);
		joystick <= 8'h0F;
		@(negedge clk_cpu);
		if (joy_p54 !== 6'b10_0000) begin
			$display("CHECK FAILED at %0t: joy_p54 all directions, got %b", $time, joy_p54);
			errors++;
		end
		@(posedge clk_cpu);
		joystick <= 8'h00;
		repeat (4) @(posedge clk_cpu);
		bus_write(16'hFF0F, 8'h00);
		r = lcg_next();
		@(posedge clk_cpu);
		joy_sgb <= r[5:0];
		read_check(16'hFF00, {2'b11, r[5:0]}, "P1 read");
		// single direction key pulls one line low and sets the flag
		@(posedge clk_cpu);
		joystick <= 8'h01;
		@(negedge clk_cpu);
		zeros = 0;
		for (int i = 0; i < 4; i++)
			if (!joy_p54[i])
				zeros++;
		if (zeros != 1) begin
			$display("CHECK FAILED at %0t: joy_p54 one key, got %b", $time, joy_p54);
			errors++;
		end
		polls = 0;
		ifv = 8'h00;
		while (!ifv[4] && polls < 10) begin
			bus_read(16'hFF0F, ifv);
			polls++;
		end
		if (!ifv[4]) begin
			$display("TIMEOUT at %0t: joypad flag never set", $time);
			errors++;
		end
		@(posedge clk_cpu);
		joystick <= 8'h00;
		repeat (4) @(posedge clk_cpu);
		bus_write(16'hFF0F, 8'h00);
		// button group is deselected
		@(posedge clk_cpu);
		joystick <= 8'h10;
		repeat (8) @(posedge clk_cpu);
		read_check(16'hFF0F, 8'hE0, "IF after deselected key");
		@(posedge clk_cpu);
		joystick <= 8'h00;
		finish_test("joypad", e0);
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		rng_state    = 32'h175e_55c3;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		reset    = 1'b1;
		is_gbc   = 1'b1;
		bus      = '0;
		irq_ack  = 1'b0;
		irq_ext  = 3'b000;
		joystick = 8'h00;
		joy_sgb  = 6'h00;
		repeat (10) @(posedge clk_cpu);
		reset <= 1'b0;
		@(negedge clk_cpu);
		test_reset_open_bus();
		test_ram_banking();
		test_irq_priority();
		test_serial();
		test_joypad();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
gb_pkg.sv
gb_bus_decode.sv
gb_irq_ctrl.sv
gb_serial_port.sv
gb_joypad.sv
gb_work_ram.sv
gb_sys_top.sv
tb_gb_sys.sv

// ==== Bender.yml ====
package:
  name: gb_sys

sources:
  - gb_pkg.sv
  - gb_bus_decode.sv
  - gb_irq_ctrl.sv
  - gb_serial_port.sv
  - gb_joypad.sv
  - gb_work_ram.sv
  - gb_sys_top.sv
  - target: test
    files:
      - tb_gb_sys.sv
